//--- source/ov_capture_pkg.sv
// Image geometry, UART timing, request byte, width types and capture FSM states
`default_nettype none

package ov_capture_pkg;

    // Full frame size in pixels
    localparam int LINES = 8;
    localparam int COLUMNS = 16;

    // One of the 2x2 quadrants
    localparam int Q_LINES = LINES / 2;
    localparam int Q_COLUMNS = COLUMNS / 2;

    // Fixed baud divider, clocks per serial bit
    localparam int CLKS_PER_BIT = 8;

    // Byte that asks the bridge for one frame
    localparam logic [7:0] START_CMD = 8'h55;

    // RGB565, high byte arrives first
    typedef logic [15:0] pixel_t;
    typedef logic [7:0] byte_t;

    // Position inside one quadrant
    typedef logic [1:0] q_line_t;
    typedef logic [2:0] q_col_t;

    // Clock count within one serial bit
    typedef logic [$clog2(CLKS_PER_BIT)-1:0] baud_cnt_t;

    // Codes also drive the state display
    typedef enum logic [3:0] {
        IDLE = 4'd0,
        SEND_CMD = 4'd1,
        WAIT_TX = 4'd2,
        WAIT_HIGH = 4'd3,
        WAIT_LOW = 4'd4,
        WRITE = 4'd5,
        NEXT = 4'd6,
        DONE = 4'd7
    } capture_state_t;

endpackage

`default_nettype wire

//--- source/ov_ctrl_if.sv
// Strobe and status bundle between capture control unit and datapath
`timescale 1ns/10ps
`default_nettype none

interface ov_ctrl_if;

    // Control unit strobes, one cycle each
    logic zera_pixel;
    logic zera_quadrante;
    logic conta_pixel;
    logic partida_serial;
    logic carrega_alto;
    logic carrega_baixo;
    logic we_byte;

    // Datapath status
    logic fim_recepcao;
    logic fim_transmissao;
    logic fim_coluna_pixel;
    logic fim_linha_pixel;
    logic fim_quadrante;

    modport uc (
        output zera_pixel, zera_quadrante, conta_pixel, partida_serial,
        output carrega_alto, carrega_baixo, we_byte,
        input  fim_recepcao, fim_transmissao, fim_coluna_pixel, fim_linha_pixel,
        input  fim_quadrante
    );

    // we_byte leaves the design at the top, the datapath never needs it
    modport fd (
        input  zera_pixel, zera_quadrante, conta_pixel, partida_serial,
        input  carrega_alto, carrega_baixo,
        output fim_recepcao, fim_transmissao, fim_coluna_pixel, fim_linha_pixel,
        output fim_quadrante
    );

endinterface

`default_nettype wire

//--- source/edge_detector.sv
// Rising edge detector producing a registered one-cycle pulse
`timescale 1ns/10ps
`default_nettype none

module edge_detector (
    input  logic clock,
    input  logic arst_n,
    input  logic sinal,
    output logic pulso
);

    // Last sampled level of the button
    logic sinal_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            sinal_q <= 1'b0;
            pulso <= 1'b0;
        end else begin
            sinal_q <= sinal;
            // High now, low last cycle
            pulso <= sinal & ~sinal_q;
        end
    end

endmodule

`default_nettype wire

//--- source/uart_rx.sv
// UART 8N1 receiver with input synchronizer, mid-bit sampling and stop-bit check
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  rx_serial,
    output ov_capture_pkg::byte_t dado,
    output logic                  valido
);
    import ov_capture_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t state;
    logic rx_meta;
    logic rx_sync;
    logic rx_prev;
    baud_cnt_t clk_cnt;
    logic [2:0] bit_cnt;
    byte_t shift;
    logic half_bit;
    logic full_bit;

    // Idle line is high, so the chain resets high
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_serial;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign half_bit = (clk_cnt == baud_cnt_t'(CLKS_PER_BIT / 2 - 1));
    assign full_bit = (clk_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= RX_IDLE;
            clk_cnt <= '0;
            bit_cnt <= '0;
            valido <= 1'b0;
        end else begin
            valido <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                    // Falling edge only, a line stuck low never restarts
                    if (rx_prev && !rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_bit) begin
                        clk_cnt <= '0;
                        // Glitch shorter than half a bit
                        state <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (full_bit) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (full_bit) begin
                        clk_cnt <= '0;
                        // Framing error drops the byte
                        valido <= rx_sync;
                        state <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB first, so new bits enter at the top
    always_ff @(posedge clock) begin
        if (state == RX_DATA && full_bit) begin
            shift <= {rx_sync, shift[7:1]};
        end
        if (state == RX_STOP && full_bit && rx_sync) begin
            dado <= shift;
        end
    end

endmodule

`default_nettype wire

//--- source/uart_tx.sv
// UART 8N1 transmitter, one frame per start strobe
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  partida,
    input  ov_capture_pkg::byte_t dado,
    output logic                  serial,
    output logic                  fim
);
    import ov_capture_pkg::*;

    logic busy;
    logic [3:0] bit_cnt;
    baud_cnt_t clk_cnt;
    // Data bits plus the stop bit
    logic [8:0] frame;
    logic last_clk;

    assign last_clk = (clk_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));
    // Last clock of the stop bit
    assign fim = busy && last_clk && (bit_cnt == 4'd9);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            bit_cnt <= '0;
            clk_cnt <= '0;
            serial <= 1'b1;
        end else if (!busy) begin
            // Start bit goes out right away
            if (partida) begin
                busy <= 1'b1;
                bit_cnt <= '0;
                clk_cnt <= '0;
                serial <= 1'b0;
            end
        end else if (last_clk) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;
            end else begin
                serial <= frame[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // Ones fill in from the top and keep the line high
    always_ff @(posedge clock) begin
        if (!busy && partida) begin
            frame <= {1'b1, dado};
        end else if (busy && last_clk) begin
            frame <= {1'b1, frame[8:1]};
        end
    end

endmodule

`default_nettype wire

//--- source/interface_ov7670_uc.sv
// Capture control unit FSM driving datapath strobes
`timescale 1ns/10ps
`default_nettype none

module interface_ov7670_uc (
    input  logic                           clock,
    input  logic                           arst_n,
    input  logic                           iniciar,
    ov_ctrl_if.uc                          ctrl,
    output ov_capture_pkg::capture_state_t db_estado
);
    import ov_capture_pkg::*;

    capture_state_t state;
    capture_state_t next_state;
    logic we_byte_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        ctrl.zera_pixel = 1'b0;
        ctrl.zera_quadrante = 1'b0;
        ctrl.conta_pixel = 1'b0;
        ctrl.partida_serial = 1'b0;
        ctrl.carrega_alto = 1'b0;
        ctrl.carrega_baixo = 1'b0;
        case (state)
            IDLE: begin
                if (iniciar) begin
                    next_state = SEND_CMD;
                end
            end
            SEND_CMD: begin
                // New frame from the top-left corner
                ctrl.zera_pixel = 1'b1;
                ctrl.zera_quadrante = 1'b1;
                ctrl.partida_serial = 1'b1;
                next_state = WAIT_TX;
            end
            WAIT_TX: begin
                // Bytes seen here are discarded
                if (ctrl.fim_transmissao) begin
                    next_state = WAIT_HIGH;
                end
            end
            WAIT_HIGH: begin
                if (ctrl.fim_recepcao) begin
                    ctrl.carrega_alto = 1'b1;
                    next_state = WAIT_LOW;
                end
            end
            WAIT_LOW: begin
                if (ctrl.fim_recepcao) begin
                    ctrl.carrega_baixo = 1'b1;
                    next_state = WRITE;
                end
            end
            WRITE: begin
                next_state = NEXT;
            end
            NEXT: begin
                // Position still belongs to the pixel just written
                ctrl.conta_pixel = 1'b1;
                next_state = ctrl.fim_quadrante ? DONE : WAIT_HIGH;
            end
            DONE: begin
                if (!iniciar) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // Write strobe lands in NEXT, before the counters move
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            we_byte_q <= 1'b0;
        end else begin
            we_byte_q <= (state == WRITE);
        end
    end

    assign ctrl.we_byte = we_byte_q;
    assign db_estado = state;

endmodule

`default_nettype wire

//--- source/interface_ov7670_fd.sv
// Capture datapath with quadrant scan counters, pixel assembly and UARTs
`timescale 1ns/10ps
`default_nettype none

module interface_ov7670_fd (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    rx_serial,
    ov_ctrl_if.fd                   ctrl,
    output logic                    saida_serial,
    output ov_capture_pkg::pixel_t  pixel,
    output ov_capture_pkg::q_line_t linha_pixel,
    output ov_capture_pkg::q_col_t  coluna_pixel,
    output logic                    linha_quadrante_addr,
    output logic                    coluna_quadrante_addr
);
    import ov_capture_pkg::*;

    byte_t rx_dado;
    byte_t byte_alto;
    byte_t byte_baixo;
    logic fim_coluna;
    logic fim_linha;

    // Bridge to camera side
    uart_rx u_rx (
        .clock     (clock),
        .arst_n    (arst_n),
        .rx_serial (rx_serial),
        .dado      (rx_dado),
        .valido    (ctrl.fim_recepcao)
    );

    // Request byte is constant
    uart_tx u_tx (
        .clock   (clock),
        .arst_n  (arst_n),
        .partida (ctrl.partida_serial),
        .dado    (START_CMD),
        .serial  (saida_serial),
        .fim     (ctrl.fim_transmissao)
    );

    assign fim_coluna = (coluna_pixel == q_col_t'(Q_COLUMNS - 1));
    assign fim_linha = (linha_pixel == q_line_t'(Q_LINES - 1));

    assign ctrl.fim_coluna_pixel = fim_coluna;
    assign ctrl.fim_linha_pixel = fim_linha;
    // Last pixel of the bottom-right quadrant
    assign ctrl.fim_quadrante = fim_coluna & fim_linha
                                & linha_quadrante_addr & coluna_quadrante_addr;

    // Row-major scan inside a quadrant
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            linha_pixel <= '0;
            coluna_pixel <= '0;
        end else if (ctrl.zera_pixel) begin
            linha_pixel <= '0;
            coluna_pixel <= '0;
        end else if (ctrl.conta_pixel) begin
            if (fim_coluna) begin
                coluna_pixel <= '0;
                linha_pixel <= fim_linha ? '0 : linha_pixel + 1'b1;
            end else begin
                coluna_pixel <= coluna_pixel + 1'b1;
            end
        end
    end

    // Quadrant order 00, 01, 10, 11 as {line, column}
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            linha_quadrante_addr <= 1'b0;
            coluna_quadrante_addr <= 1'b0;
        end else if (ctrl.zera_quadrante) begin
            linha_quadrante_addr <= 1'b0;
            coluna_quadrante_addr <= 1'b0;
        end else if (ctrl.conta_pixel && fim_coluna && fim_linha) begin
            {linha_quadrante_addr, coluna_quadrante_addr} <=
                {linha_quadrante_addr, coluna_quadrante_addr} + 2'd1;
        end
    end

    // High byte first on the wire
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            byte_alto <= '0;
            byte_baixo <= '0;
        end else begin
            if (ctrl.carrega_alto) begin
                byte_alto <= rx_dado;
            end
            if (ctrl.carrega_baixo) begin
                byte_baixo <= rx_dado;
            end
        end
    end

    assign pixel = {byte_alto, byte_baixo};

endmodule

`default_nettype wire

//--- source/hexa7seg.sv
// Hex nibble to active-low 7-segment decoder
`timescale 1ns/10ps
`default_nettype none

module hexa7seg (
    input  logic [3:0] hexa,
    output logic [6:0] display
);

    // Lit segments, bit 0 is a and bit 6 is g
    logic [6:0] seg_on;

    always_comb begin
        case (hexa)
            4'h0: seg_on = 7'h3f;
            4'h1: seg_on = 7'h06;
            4'h2: seg_on = 7'h5b;
            4'h3: seg_on = 7'h4f;
            4'h4: seg_on = 7'h66;
            4'h5: seg_on = 7'h6d;
            4'h6: seg_on = 7'h7d;
            4'h7: seg_on = 7'h07;
            4'h8: seg_on = 7'h7f;
            4'h9: seg_on = 7'h6f;
            4'ha: seg_on = 7'h77;
            4'hb: seg_on = 7'h7c;
            4'hc: seg_on = 7'h39;
            4'hd: seg_on = 7'h5e;
            4'he: seg_on = 7'h79;
            default: seg_on = 7'h71;
        endcase
    end

    // Board segments light on a low level
    assign display = ~seg_on;

endmodule

`default_nettype wire

//--- source/interface_ov7670.sv
// Frame capture top level with edge detector, control unit, datapath and displays
`timescale 1ns/10ps
`default_nettype none

module interface_ov7670 (
    input  logic        clock,
    input  logic        arst_n,
    input  logic        iniciar,
    input  logic        rx_serial,
    output logic        saida_serial,
    output logic        db_partida_serial,
    output logic        we_byte,
    output logic [15:0] pixel,
    output logic [1:0]  linha_pixel,
    output logic [2:0]  coluna_pixel,
    output logic        linha_quadrante_addr,
    output logic        coluna_quadrante_addr,
    output logic [6:0]  db_estado,
    output logic [6:0]  hex0_pixel,
    output logic [6:0]  hex1_pixel,
    output logic [6:0]  hex2_pixel,
    output logic [6:0]  hex3_pixel,
    output logic [6:0]  hex4_pixel,
    output logic        db_fim_recepcao
);
    import ov_capture_pkg::*;

    logic iniciar_pulso;
    capture_state_t estado;

    ov_ctrl_if ctrl ();

    // Button to single start pulse
    edge_detector u_edge (
        .clock  (clock),
        .arst_n (arst_n),
        .sinal  (iniciar),
        .pulso  (iniciar_pulso)
    );

    interface_ov7670_uc u_uc (
        .clock     (clock),
        .arst_n    (arst_n),
        .iniciar   (iniciar_pulso),
        .ctrl      (ctrl.uc),
        .db_estado (estado)
    );

    interface_ov7670_fd u_fd (
        .clock                 (clock),
        .arst_n                (arst_n),
        .rx_serial             (rx_serial),
        .ctrl                  (ctrl.fd),
        .saida_serial          (saida_serial),
        .pixel                 (pixel),
        .linha_pixel           (linha_pixel),
        .coluna_pixel          (coluna_pixel),
        .linha_quadrante_addr  (linha_quadrante_addr),
        .coluna_quadrante_addr (coluna_quadrante_addr)
    );

    // Debug taps
    assign we_byte = ctrl.we_byte;
    assign db_partida_serial = ctrl.partida_serial;
    assign db_fim_recepcao = ctrl.fim_recepcao;

    // State code
    hexa7seg u_hex_estado (.hexa(estado), .display(db_estado));

    // Pixel nibbles, lowest on hex0
    hexa7seg u_hex0 (.hexa(pixel[3:0]), .display(hex0_pixel));
    hexa7seg u_hex1 (.hexa(pixel[7:4]), .display(hex1_pixel));
    hexa7seg u_hex2 (.hexa(pixel[11:8]), .display(hex2_pixel));
    hexa7seg u_hex3 (.hexa(pixel[15:12]), .display(hex3_pixel));

    // Column inside the quadrant
    hexa7seg u_hex4 (.hexa({1'b0, coluna_pixel}), .display(hex4_pixel));

endmodule

`default_nettype wire

//--- verification/tb_uart_model.svh
// Serial line tasks: byte sender toward the DUT receiver and decoder for the DUT transmitter
`ifndef TB_UART_MODEL_SVH
`define TB_UART_MODEL_SVH

// Drives one 8N1 frame on rx_serial, then holds the line idle for gap_cycles
// Called in a drive slot, returns in a drive slot
task automatic send_serial_byte(
    input logic [7:0] data,
    input logic       stop_level,
    input int         gap_cycles
);
    logic [9:0] frame;
    int bit_idx;

    // Start bit, data LSB first, stop bit
    frame = {stop_level, data, 1'b0};
    for (bit_idx = 0; bit_idx < 10; bit_idx++) begin
        rx_serial = frame[bit_idx];
        repeat (CLKS_PER_BIT) @(posedge clock);
        #(DRIVE_DELAY);
    end
    // Idle high between bytes
    rx_serial = 1'b1;
    repeat (gap_cycles) @(posedge clock);
    #(DRIVE_DELAY);
endtask

// Decodes one frame from saida_serial, sampling on falling clock edges
task automatic read_serial_byte(
    output logic [7:0] data,
    output logic       stop_bit
);
    int bit_idx;

    while (saida_serial !== 1'b0) @(negedge clock);
    // Middle of the start bit
    repeat (CLKS_PER_BIT / 2) @(negedge clock);
    check_value("request start bit", 32'd0, 32'(saida_serial));
    for (bit_idx = 0; bit_idx < 8; bit_idx++) begin
        repeat (CLKS_PER_BIT) @(negedge clock);
        data[bit_idx] = saida_serial;
    end
    repeat (CLKS_PER_BIT) @(negedge clock);
    stop_bit = saida_serial;
endtask

`endif

//--- verification/tb_interface_ov7670.sv
// Testbench top for the frame capture subsystem with scan model, checks and watchdog
`timescale 1ns/10ps
`default_nettype none

module tb_interface_ov7670;
    import ov_capture_pkg::*;

    localparam int CLK_HALF = 20;
    localparam int CLK_PERIOD = 2 * CLK_HALF;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY = 2;
    localparam int RANDOM_SEED = 83591;
    localparam int NUM_FRAMES = 2;
    localparam int FRAME_PIXELS = LINES * COLUMNS;
    localparam int QUAD_PIXELS = Q_LINES * Q_COLUMNS;
    // Idle gap between bytes in whole bit times
    localparam int MAX_GAP_BITS = 3;
    localparam int BYTE_CYCLES = (10 + MAX_GAP_BITS) * CLKS_PER_BIT;
    // Two bytes per pixel plus the request and one corrupted byte
    localparam int FRAME_BYTES = 2 * FRAME_PIXELS + 2;
    localparam int MARGIN_CYCLES = 1000;
    localparam int WATCHDOG_NS =
        (RESET_CYCLES + NUM_FRAMES * FRAME_BYTES * BYTE_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

    logic        clock;
    logic        arst_n;
    logic        iniciar;
    logic        rx_serial;
    logic        saida_serial;
    logic        db_partida_serial;
    logic        we_byte;
    logic [15:0] pixel;
    logic [1:0]  linha_pixel;
    logic [2:0]  coluna_pixel;
    logic        linha_quadrante_addr;
    logic        coluna_quadrante_addr;
    logic [6:0]  db_estado;
    logic [6:0]  hex0_pixel;
    logic [6:0]  hex1_pixel;
    logic [6:0]  hex2_pixel;
    logic [6:0]  hex3_pixel;
    logic [6:0]  hex4_pixel;
    logic        db_fim_recepcao;

    // Reference model with one entry per expected write
    logic [15:0] exp_pixel_q[$];
    logic [6:0]  exp_addr_q[$];

    // Monitor bookkeeping
    int neg_cycle = 0;
    int last_rx_cycle = 0;
    int rx_pulses = 0;
    int writes_seen = 0;
    int frame_writes = 0;
    int frames_checked = 0;
    bit done_pending = 1'b0;
    int unsigned seed_init;
    int frame_idx;

    interface_ov7670 DUT (
        .clock                 (clock),
        .arst_n                (arst_n),
        .iniciar               (iniciar),
        .rx_serial             (rx_serial),
        .saida_serial          (saida_serial),
        .db_partida_serial     (db_partida_serial),
        .we_byte               (we_byte),
        .pixel                 (pixel),
        .linha_pixel           (linha_pixel),
        .coluna_pixel          (coluna_pixel),
        .linha_quadrante_addr  (linha_quadrante_addr),
        .coluna_quadrante_addr (coluna_quadrante_addr),
        .db_estado             (db_estado),
        .hex0_pixel            (hex0_pixel),
        .hex1_pixel            (hex1_pixel),
        .hex2_pixel            (hex2_pixel),
        .hex3_pixel            (hex3_pixel),
        .hex4_pixel            (hex4_pixel),
        .db_fim_recepcao       (db_fim_recepcao)
    );

    always #(CLK_HALF) clock = ~clock;

    task automatic check_value(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (actual !== expected) begin
            $display("CHECK FAILED: %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    `include "tb_uart_model.svh"

    // Active-low segment patterns with g as the top bit
    function automatic logic [6:0] seven_seg_pattern(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'ha: return 7'b0001000;
            4'hb: return 7'b0000011;
            4'hc: return 7'b1000110;
            4'hd: return 7'b0100001;
            4'he: return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    // Capture index to {quad line, quad col, line, col}
    // Quadrants go TL TR BL BR and each one row by row
    function automatic logic [6:0] scan_address(input int index);
        int quadrant;
        int offset;
        quadrant = index / QUAD_PIXELS;
        offset = index % QUAD_PIXELS;
        return {quadrant[1], quadrant[0], 2'(offset / Q_COLUMNS), 3'(offset % Q_COLUMNS)};
    endfunction

    function automatic int random_gap_cycles();
        return CLKS_PER_BIT * int'($urandom_range(MAX_GAP_BITS, 1));
    endfunction

    task automatic wait_drive_slot();
        @(posedge clock);
        #(DRIVE_DELAY);
    endtask

    // One write pulse against the head of the model queue
    task automatic check_write();
        logic [15:0] exp_pix;
        logic [6:0] exp_addr;
        check_value("write with pixel pending", 32'd1, 32'(exp_pixel_q.size() > 0));
        exp_pix = exp_pixel_q.pop_front();
        exp_addr = exp_addr_q.pop_front();
        check_value("pixel value", 32'(exp_pix), 32'(pixel));
        check_value("scan address", 32'(exp_addr),
            32'({linha_quadrante_addr, coluna_quadrante_addr, linha_pixel, coluna_pixel}));
        // Second byte strobe to write strobe
        check_value("write latency", 32'd2, neg_cycle - last_rx_cycle);
        check_value("hex0", 32'(seven_seg_pattern(exp_pix[3:0])), 32'(hex0_pixel));
        check_value("hex1", 32'(seven_seg_pattern(exp_pix[7:4])), 32'(hex1_pixel));
        check_value("hex2", 32'(seven_seg_pattern(exp_pix[11:8])), 32'(hex2_pixel));
        check_value("hex3", 32'(seven_seg_pattern(exp_pix[15:12])), 32'(hex3_pixel));
        check_value("hex4", 32'(seven_seg_pattern({1'b0, exp_addr[2:0]})), 32'(hex4_pixel));
        writes_seen++;
        frame_writes++;
        if (frame_writes == FRAME_PIXELS) begin
            done_pending = 1'b1;
            frame_writes = 0;
        end
    endtask

    // Outputs settle long before the falling edge
    always @(negedge clock) begin
        neg_cycle++;
        if (done_pending) begin
            // State one cycle after the last write
            check_value("state after frame", 32'(seven_seg_pattern(DONE)), 32'(db_estado));
            done_pending = 1'b0;
            frames_checked++;
        end else if (db_estado === seven_seg_pattern(DONE)) begin
            check_value("pulses per frame", FRAME_PIXELS, frame_writes);
        end
        if (db_fim_recepcao === 1'b1) begin
            rx_pulses++;
            last_rx_cycle = neg_cycle;
        end
        if (we_byte === 1'b1) begin
            check_write();
        end
    end

    // Request and then a full random frame with one corrupted byte inside a pixel
    task automatic run_frame(input int frame_num, input int bad_index);
        logic [15:0] pix;
        logic [7:0] req;
        logic stop_bit;
        int k;
        int n;
        int rx_before;
        int partida_cycle;

        while (db_estado !== seven_seg_pattern(IDLE)) @(negedge clock);
        wait_drive_slot();
        iniciar = 1'b1;
        // Button press to request start bit
        n = 0;
        partida_cycle = 0;
        while (saida_serial !== 1'b0 && n < 10) begin
            @(posedge clock);
            n++;
            @(negedge clock);
            if (db_partida_serial === 1'b1) begin
                partida_cycle = n;
            end
        end
        check_value("request latency", 32'd3, n);
        // Transmitter strobe one cycle before the start bit
        check_value("request strobe cycle", 32'd2, partida_cycle);
        read_serial_byte(req, stop_bit);
        check_value("request byte", 32'(START_CMD), 32'(req));
        check_value("request stop bit", 32'd1, 32'(stop_bit));
        wait_drive_slot();
        iniciar = 1'b0;
        while (db_estado !== seven_seg_pattern(WAIT_HIGH)) @(negedge clock);
        wait_drive_slot();

        for (k = 0; k < FRAME_PIXELS; k++) begin
            pix = 16'($urandom());
            exp_pixel_q.push_back(pix);
            exp_addr_q.push_back(scan_address(k));
            send_serial_byte(pix[15:8], 1'b1, random_gap_cycles());
            if (k == bad_index) begin
                // Receiver drops a byte whose stop bit is low
                rx_before = rx_pulses;
                send_serial_byte(8'($urandom()), 1'b0, random_gap_cycles());
                check_value("strobe on framing error", rx_before, rx_pulses);
            end
            send_serial_byte(pix[7:0], 1'b1, random_gap_cycles());
        end

        while (frames_checked <= frame_num) @(negedge clock);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the frames did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed_init = $urandom(RANDOM_SEED);
        clock = 1'b0;
        arst_n = 1'b0;
        iniciar = 1'b0;
        rx_serial = 1'b1;

        repeat (RESET_CYCLES) @(posedge clock);
        #(DRIVE_DELAY);
        arst_n = 1'b1;

        // Idle outputs out of reset
        @(negedge clock);
        check_value("reset saida_serial", 32'd1, 32'(saida_serial));
        check_value("reset we_byte", 32'd0, 32'(we_byte));
        check_value("reset db_partida_serial", 32'd0, 32'(db_partida_serial));
        check_value("reset state", 32'(seven_seg_pattern(IDLE)), 32'(db_estado));
        check_value("reset pixel", 32'd0, 32'(pixel));
        check_value("reset address", 32'd0,
            32'({linha_quadrante_addr, coluna_quadrante_addr, linha_pixel, coluna_pixel}));
        wait_drive_slot();

        for (frame_idx = 0; frame_idx < NUM_FRAMES; frame_idx++) begin
            run_frame(frame_idx, int'($urandom_range(FRAME_PIXELS - 1, 0)));
        end

        if (writes_seen == NUM_FRAMES * FRAME_PIXELS && exp_pixel_q.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("CHECK FAILED: total writes expected %0d actual %0d",
                NUM_FRAMES * FRAME_PIXELS, writes_seen);
            $display("TEST RESULT: FAIL");
            $fatal(1, "write count mismatch");
        end
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+verification
source/ov_capture_pkg.sv
source/ov_ctrl_if.sv
source/edge_detector.sv
source/uart_rx.sv
source/uart_tx.sv
source/interface_ov7670_uc.sv
source/interface_ov7670_fd.sv
source/hexa7seg.sv
source/interface_ov7670.sv
verification/tb_interface_ov7670.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_interface_ov7670
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary -j 0

RTL_SRCS := $(wildcard source/*.sv)
TB_SRCS := verification/tb_interface_ov7670.sv verification/tb_uart_model.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(RTL_SRCS) $(TB_SRCS) $(FLIST)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# Exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
